//--- tb.f
core_pkg.sv
core_if.sv
inst_decode.sv
reg_file.sv
exec_unit.sv
pc_unit.sv
lsu_writeback.sv
rv_core_top.sv
tb_clk_gen.sv
tb_core.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core -f tb.f -o tb_core_sim \
  > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_core_sim > sim.log 2>&1 || { cat sim.log; echo "run failed"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

//--- tb_core.sv
`default_nettype none

module tb_core;

  localparam logic [31:0] reset_pc = 32'h8000_0000;
  localparam int total_steps = 104;  // sum of all trace lengths
  localparam int num_tests   = 6;
  localparam int limit       = 4 * total_steps + 12 * (num_tests + 1);

  wire logic   clk;
  wire logic   rst_n;
  logic        reset_req;
  logic [31:0] inst;
  logic [31:0] mem_rdata;
  logic [31:0] pc;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wmask;
  logic        mem_ren;
  logic        mem_wen;
  logic        halted;

  int          seed = 32'hbc19;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic        mem_ready = 1'b0;
  logic [31:0] mem [256];
  logic [31:0] cur_pc;
  logic [31:0] tr_inst [$];
  logic [31:0] tr_pc [$];
  logic [31:0] obs_wen [$];
  logic [31:0] obs_addr [$];
  logic [31:0] obs_mask [$];
  logic [31:0] obs_data [$];
  logic [31:0] obs_halt [$];
  int          ex_step [$];
  logic [31:0] ex_addr [$];
  logic [3:0]  ex_mask [$];
  logic [31:0] ex_data [$];

  tb_clk_gen clk_gen (.reset_req(reset_req), .clk(clk), .rst_n(rst_n));

  rv_core_top #(.reset_pc(reset_pc)) dut (
    .clk(clk), .rst_n(rst_n), .inst(inst), .mem_rdata(mem_rdata), .pc(pc),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .halted(halted)
  );

  // data memory with combinational read and byte-masked write
  assign mem_rdata = mem_ren ? mem[mem_addr[9:2]] : 32'hdead_beef;  // data only on a read

  always @(posedge clk) begin
    if (!mem_ready) begin
      for (int i = 0; i < 256; i++) mem[i] <= $random(seed);
      mem_ready <= 1'b1;
    end else if (mem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wmask[b]) mem[mem_addr[9:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout reached after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_word(logic [31:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // lane extraction by access size where misaligned gives zero
  function automatic logic [31:0] load_expect(logic [31:0] w, logic [2:0] f3, int off);
    logic [31:0] s;
    s = w >> (8 * off);
    case (f3)
      3'd0: return {{24{s[7]}}, s[7:0]};
      3'd4: return {24'h0, s[7:0]};
      3'd1: return (off % 2 != 0) ? 32'h0 : {{16{s[15]}}, s[15:0]};
      3'd5: return (off % 2 != 0) ? 32'h0 : {16'h0, s[15:0]};
      default: return (off != 0) ? 32'h0 : w;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, act, exp);
    end
  endtask

  task automatic clear_trace();
    tr_inst.delete();
    tr_pc.delete();
    ex_step.delete();
    ex_addr.delete();
    ex_mask.delete();
    ex_data.delete();
    obs_wen.delete();
    obs_addr.delete();
    obs_mask.delete();
    obs_data.delete();
    obs_halt.delete();
    cur_pc = reset_pc;
  endtask

  task automatic push(input logic [31:0] i);
    tr_inst.push_back(i);
    tr_pc.push_back(cur_pc);
    cur_pc = cur_pc + 32'd4;
  endtask

  // store with base x0 and the bus values it should produce
  task automatic push_store(input logic [4:0] rs2, input logic [2:0] f3, input logic [11:0] addr,
                            input logic [3:0] mask, input logic [31:0] data);
    push({addr[11:5], rs2, 5'd0, f3, addr[4:0], 7'h23});
    ex_step.push_back(tr_inst.size() - 1);
    ex_addr.push_back({20'h0, addr[11:2], 2'b00});
    ex_mask.push_back(mask);
    ex_data.push_back(data);
  endtask

  task automatic do_reset();
    @(posedge clk);
    reset_req <= 1'b1;
    inst <= tr_inst[0];
    @(posedge clk);
    reset_req <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check("pc", pc, reset_pc);  // held in reset
    check("halted", {31'h0, halted}, 32'h0);
    check("mem_wen", {31'h0, mem_wen}, 32'h0);
    check("mem_ren", {31'h0, mem_ren}, 32'h0);
    while (!rst_n) @(negedge clk);
  endtask

  task automatic run_trace();
    int s;
    do_reset();
    for (int k = 0; k < tr_inst.size(); k++) begin
      check("pc", pc, tr_pc[k]);
      obs_wen.push_back({31'h0, mem_wen});
      obs_addr.push_back(mem_addr);
      obs_mask.push_back({28'h0, mem_wmask});
      obs_data.push_back(mem_wdata);
      obs_halt.push_back({31'h0, halted});
      @(posedge clk);
      inst <= (k + 1 < tr_inst.size()) ? tr_inst[k + 1] : 32'h0000_0013;
      @(negedge clk);
    end
    foreach (ex_step[i]) begin
      s = ex_step[i];
      check("mem_wen", obs_wen[s], 32'h1);
      check("mem_addr", obs_addr[s], ex_addr[i]);
      check("mem_wmask", obs_mask[s], {28'h0, ex_mask[i]});
      if (ex_mask[i] != 4'h0) check("mem_wdata", obs_data[s], ex_data[i]);
    end
  endtask

  task automatic reset_values();
    clear_trace();
    push(i_word(12'h100, 5'd0, 3'd2, 5'd10, 7'h03));  // load present during reset
    push_store(5'd0, 3'd2, 12'h020, 4'hf, 32'h0);
    run_trace();
  endtask

  task automatic arith_results();
    logic [31:0] imm;
    logic [31:0] u;
    logic [31:0] p;
    clear_trace();
    for (int n = 0; n < 4; n++) begin
      imm = $random(seed);
      u = $random(seed);
      push(i_word(imm[11:0], 5'd0, 3'd0, 5'd1, 7'h13));
      push_store(5'd1, 3'd2, 12'h000, 4'hf, sext12(imm[11:0]));
      push(u_word(u[19:0], 5'd2, 7'h37));
      push_store(5'd2, 3'd2, 12'h004, 4'hf, {u[19:0], 12'h0});
      p = cur_pc;
      push(u_word(u[31:12], 5'd3, 7'h17));
      push_store(5'd3, 3'd2, 12'h008, 4'hf, p + {u[31:12], 12'h0});
      push(i_word(u[11:0], 5'd1, 3'd0, 5'd4, 7'h13));  // chained addi
      push_store(5'd4, 3'd2, 12'h00c, 4'hf, sext12(imm[11:0]) + sext12(u[11:0]));
    end
    run_trace();
  endtask

  task automatic jump_targets();
    logic [31:0] r;
    logic [31:0] off;
    logic [31:0] p;
    logic [11:0] b;
    logic [11:0] jimm;
    clear_trace();
    for (int n = 0; n < 2; n++) begin
      r = $random(seed);
      off = {{20{r[9]}}, r[9:0], 2'b00};
      p = cur_pc;
      push(j_word(off, 5'd1));
      cur_pc = p + off;
      push_store(5'd1, 3'd2, 12'h010, 4'hf, p + 32'd4);
      b = {1'b0, r[18:11], 3'b001};  // odd base so jalr drops bit 0
      jimm = {2'b00, r[28:21], 2'b00};
      push(i_word(b, 5'd0, 3'd0, 5'd5, 7'h13));
      p = cur_pc;
      push(i_word(jimm, 5'd5, 3'd0, 5'd6, 7'h67));
      cur_pc = ({20'h0, b} + {20'h0, jimm}) & ~32'h1;
      push_store(5'd6, 3'd2, 12'h014, 4'hf, p + 32'd4);
    end
    run_trace();
  endtask

  task automatic load_lanes();
    logic [31:0] w;
    int slot;
    clear_trace();
    w = mem[64];  // word at 0x100
    for (int f = 0; f < 6; f++) begin
      if (f == 3) continue;
      for (int off = 0; off < 4; off++) begin
        slot = (f > 3 ? f - 1 : f) * 4 + off;
        push(i_word(12'(32'h100 + off), 5'd0, f[2:0], 5'd10, 7'h03));
        push_store(5'd10, 3'd2, 12'(32'h200 + 4 * slot), 4'hf, load_expect(w, f[2:0], off));
      end
    end
    run_trace();
  endtask

  task automatic store_lanes();
    logic [31:0] v;
    logic [3:0] m;
    clear_trace();
    v = $random(seed);
    push(u_word(v[31:12] + {19'h0, v[11]}, 5'd7, 7'h37));
    push(i_word(v[11:0], 5'd7, 3'd0, 5'd7, 7'h13));
    for (int f = 0; f < 3; f++) begin
      for (int off = 0; off < 4; off++) begin
        if (f == 0) m = 4'(1 << off);
        else if (f == 1) m = (off % 2 == 0) ? 4'(3 << off) : 4'h0;
        else m = (off == 0) ? 4'hf : 4'h0;
        push_store(5'd7, f[2:0], 12'(32'h300 + off), m, v << (8 * off));
      end
    end
    run_trace();
  endtask

  task automatic halt_freeze();
    logic [31:0] p;
    clear_trace();
    push(i_word(12'h005, 5'd0, 3'd0, 5'd1, 7'h13));
    push(32'h0010_0073);  // ebreak
    p = cur_pc;
    for (int n = 0; n < 4; n++) begin
      cur_pc = p;  // frozen
      push(i_word(12'h018, 5'd1, 3'd2, 5'd0, 7'h00) | 32'h0000_0023);
    end
    run_trace();
    check("halted", obs_halt[1], 32'h0);
    for (int k = 2; k < 6; k++) begin
      check("halted", obs_halt[k], 32'h1);
      check("mem_wen", obs_wen[k], 32'h0);
    end
  endtask

  initial begin
    reset_req <= 1'b0;
    inst <= 32'h0;
    reset_values();
    arith_results();
    jump_targets();
    load_lanes();
    store_lanes();
    halt_freeze();
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int half_period  = 2,
  parameter int reset_cycles = 8
) (
  input  wire logic reset_req,
  output logic      clk,
  output logic      rst_n
);

  int hold = reset_cycles;  // low from power-up

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // a request restarts the reset window
  always @(posedge clk) begin
    if (reset_req) hold <= reset_cycles;
    else if (hold != 0) hold <= hold - 1;
  end

  assign rst_n = (hold == 0);

endmodule

`default_nettype wire

//--- rv_core_top.sv
`default_nettype none

module rv_core_top import core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = default_reset_pc
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic [xlen-1:0] inst,
  input  wire logic [xlen-1:0] mem_rdata,
  output logic      [xlen-1:0] pc,
  output logic      [xlen-1:0] mem_addr,
  output logic      [xlen-1:0] mem_wdata,
  output logic      [3:0]      mem_wmask,
  output logic                 mem_ren,
  output logic                 mem_wen,
  output logic                 halted
);

  ctrl_if ctrl ();
  exec_if ex ();

  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic                  rf_wen;
  logic [xlen-1:0]       rf_wdata;

  inst_decode u_decode (
    .inst     (inst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .ctrl     (ctrl.dec)
  );

  reg_file #(
    .addr_w (reg_addr_w)
  ) u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (ctrl.rd),
    .wen      (rf_wen),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit u_exec (
    .pc       (pc),
    .rs1_data (rs1_data),
    .ctrl     (ctrl.sink),
    .ex       (ex.src)
  );

  pc_unit #(
    .reset_pc (reset_pc)
  ) u_pc (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl   (ctrl.sink),
    .ex     (ex.sink),
    .pc     (pc),
    .halted (halted)
  );

  lsu_writeback u_lsu (
    .rst_n     (rst_n),
    .halted    (halted),
    .rs2_data  (rs2_data),
    .mem_rdata (mem_rdata),
    .ctrl      (ctrl.sink),
    .ex        (ex.sink),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .rf_wen    (rf_wen),
    .rf_wdata  (rf_wdata)
  );

endmodule

`default_nettype wire

//--- lsu_writeback.sv
`default_nettype none

module lsu_writeback import core_pkg::*; (
  input  wire logic            rst_n,
  input  wire logic            halted,
  input  wire logic [xlen-1:0] rs2_data,
  input  wire logic [xlen-1:0] mem_rdata,
  ctrl_if.sink                 ctrl,
  exec_if.sink                 ex,
  output logic      [xlen-1:0] mem_addr,
  output logic      [xlen-1:0] mem_wdata,
  output logic      [3:0]      mem_wmask,
  output logic                 mem_ren,
  output logic                 mem_wen,
  output logic                 rf_wen,
  output logic      [xlen-1:0] rf_wdata
);

  logic [1:0]      lane;
  logic            aligned;
  logic            active;
  logic [xlen-1:0] rdata_sh;
  logic [xlen-1:0] load_data;

  assign lane     = ex.sum[1:0];
  assign mem_addr = {ex.sum[xlen-1:2], 2'b00};  // word address

  always_comb begin
    case (ctrl.funct3)
      sz_b, sz_bu: aligned = 1'b1;
      sz_h, sz_hu: aligned = ~lane[0];
      sz_w:        aligned = (lane == 2'b00);
      default:     aligned = 1'b0;
    endcase
  end

  // move the addressed lane down to bit 0
  assign rdata_sh = mem_rdata >> {lane, 3'b000};

  always_comb begin
    case (ctrl.funct3)
      sz_b:    load_data = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
      sz_bu:   load_data = {24'h000000, rdata_sh[7:0]};
      sz_h:    load_data = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
      sz_hu:   load_data = {16'h0000, rdata_sh[15:0]};
      sz_w:    load_data = mem_rdata;
      default: load_data = '0;
    endcase
    if (!aligned) begin
      load_data = '0;  // misaligned load returns zero
    end
  end

  // store data goes into its lane, mask follows size and offset
  assign mem_wdata = rs2_data << {lane, 3'b000};

  always_comb begin
    case (ctrl.funct3)
      sz_b:    mem_wmask = 4'b0001 << lane;
      sz_h:    mem_wmask = 4'b0011 << lane;
      sz_w:    mem_wmask = 4'b1111;
      default: mem_wmask = 4'b0000;
    endcase
    if (!aligned) begin
      mem_wmask = 4'b0000;
    end
  end

  always_comb begin
    case (ctrl.wb_sel)
      wb_alu:  rf_wdata = ex.sum;
      wb_link: rf_wdata = ex.link;
      wb_imm:  rf_wdata = ctrl.imm;
      wb_load: rf_wdata = load_data;
      default: rf_wdata = ex.sum;
    endcase
  end

  // nothing reaches memory or the register file in reset or after halt
  assign active  = rst_n && !halted;
  assign mem_ren = ctrl.mem_ren && active;
  assign mem_wen = ctrl.mem_wen && active;
  assign rf_wen  = ctrl.reg_wen && active;

  // memory port carries one access per cycle
  always_comb begin
    assert final (!(mem_ren && mem_wen))
      else $error("lsu: read and write requested together at %h", mem_addr);
  end

endmodule

`default_nettype wire

//--- pc_unit.sv
`default_nettype none

module pc_unit import core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = default_reset_pc
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  ctrl_if.sink                 ctrl,
  exec_if.sink                 ex,
  output logic      [xlen-1:0] pc,
  output logic                 halted
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= reset_pc;
      halted <= 1'b0;
    end else if (!halted) begin
      pc <= ex.next_pc;
      if (ctrl.is_halt) begin
        halted <= 1'b1;  // sticky until reset
      end
    end
  end

  // jump targets from decode and execute must stay word aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00
  ) else $error("pc_unit: misaligned pc %h", pc);

endmodule

`default_nettype wire

//--- exec_unit.sv
`default_nettype none

module exec_unit import core_pkg::*; (
  input  wire logic [xlen-1:0] pc,
  input  wire logic [xlen-1:0] rs1_data,
  ctrl_if.sink                 ctrl,
  exec_if.src                  ex
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] link;

  // pc-relative forms take pc as the base
  always_comb begin
    case (ctrl.opcode)
      op_auipc, op_jal: op_a = pc;
      default:          op_a = rs1_data;
    endcase
  end

  // one adder serves addi, auipc, jumps and address generation
  assign sum  = op_a + ctrl.imm;
  assign link = pc + 32'd4;

  always_comb begin
    if (ctrl.is_jump) begin
      if (ctrl.opcode == op_jalr) begin
        ex.next_pc = {sum[xlen-1:1], 1'b0};
      end else begin
        ex.next_pc = sum;  // jal
      end
    end else begin
      ex.next_pc = link;
    end
  end

  assign ex.sum  = sum;
  assign ex.link = link;

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file import core_pkg::*; #(
  parameter int addr_w = 5
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic [addr_w-1:0] rs1_addr,
  input  wire logic [addr_w-1:0] rs2_addr,
  input  wire logic [addr_w-1:0] rd_addr,
  input  wire logic              wen,
  input  wire logic [xlen-1:0]   wdata,
  output logic      [xlen-1:0]   rs1_data,
  output logic      [xlen-1:0]   rs2_data
);

  logic [xlen-1:0] regs [2**addr_w];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd_addr != '0)) begin
      regs[rd_addr] <= wdata;  // x0 never written
    end
  end

  // combinational reads, x0 forced to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- inst_decode.sv
`default_nettype none

module inst_decode import core_pkg::*; (
  input  wire logic [xlen-1:0]       inst,
  output logic      [reg_addr_w-1:0] rs1_addr,
  output logic      [reg_addr_w-1:0] rs2_addr,
  ctrl_if.dec                        ctrl
);

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [2:0]      f3;
  opcode_e         opc;

  assign opc = opcode_e'(inst[6:0]);
  assign f3  = inst[14:12];

  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  // immediate formats sign extended from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign ctrl.opcode = opc;
  assign ctrl.funct3 = mem_size_e'(f3);
  assign ctrl.rd     = inst[11:7];

  always_comb begin
    ctrl.imm     = '0;
    ctrl.reg_wen = 1'b0;
    ctrl.mem_ren = 1'b0;
    ctrl.mem_wen = 1'b0;
    ctrl.wb_sel  = wb_alu;
    ctrl.is_jump = 1'b0;
    ctrl.is_halt = 1'b0;
    case (opc)
      op_imm: begin
        ctrl.imm     = imm_i;
        ctrl.reg_wen = (f3 == 3'b000);  // other op-imm ops fall through as no-ops
      end
      op_lui: begin
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
        ctrl.wb_sel  = wb_imm;
      end
      op_auipc: begin
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
      end
      op_jal: begin
        ctrl.imm     = imm_j;
        ctrl.reg_wen = 1'b1;
        ctrl.wb_sel  = wb_link;
        ctrl.is_jump = 1'b1;
      end
      op_jalr: begin
        ctrl.imm     = imm_i;
        ctrl.reg_wen = 1'b1;
        ctrl.wb_sel  = wb_link;
        ctrl.is_jump = 1'b1;
      end
      op_load: begin
        ctrl.imm     = imm_i;
        ctrl.reg_wen = 1'b1;
        ctrl.mem_ren = 1'b1;
        ctrl.wb_sel  = wb_load;
      end
      op_store: begin
        ctrl.imm     = imm_s;
        ctrl.mem_wen = 1'b1;
      end
      op_system: ctrl.is_halt = (inst[31:7] == 25'h0002000);  // ebreak only
      default: ;  // unknown opcode gives plain pc + 4
    endcase
  end

endmodule

`default_nettype wire

//--- core_if.sv
`default_nettype none

// decoded control from inst_decode to the datapath
interface ctrl_if import core_pkg::*; ();
  opcode_e         opcode;
  mem_size_e       funct3;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0] imm;
  logic            reg_wen;
  logic            mem_ren;
  logic            mem_wen;
  wb_sel_e         wb_sel;
  logic            is_jump;
  logic            is_halt;

  modport dec (
    output opcode, funct3, rd, imm, reg_wen, mem_ren, mem_wen, wb_sel, is_jump, is_halt
  );
  modport sink (
    input opcode, funct3, rd, imm, reg_wen, mem_ren, mem_wen, wb_sel, is_jump, is_halt
  );
endinterface

// adder result and pc candidates from exec_unit
interface exec_if import core_pkg::*; ();
  logic [xlen-1:0] sum;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] link;

  modport src (
    output sum, next_pc, link
  );
  modport sink (
    input sum, next_pc, link
  );
endinterface

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

  // datapath and register index widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // reset vector, overridable from the top level
  localparam logic [xlen-1:0] default_reset_pc = 32'h8000_0000;

  // major opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    op_imm    = 7'b001_0011,  // addi only
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_system = 7'b111_0011   // ebreak
  } opcode_e;

  // load/store access size, straight from funct3
  typedef enum logic [2:0] {
    sz_b  = 3'b000,
    sz_h  = 3'b001,
    sz_w  = 3'b010,
    sz_bu = 3'b100,
    sz_hu = 3'b101
  } mem_size_e;

  // register writeback source
  typedef enum logic [1:0] {
    wb_alu  = 2'b00,  // adder result
    wb_link = 2'b01,  // pc + 4
    wb_imm  = 2'b10,  // u-type immediate (lui)
    wb_load = 2'b11   // extracted load data
  } wb_sel_e;

endpackage

`default_nettype wire
